//--- verilog/cnn_pkg.sv
package cnn_pkg;

    // Operation codes carried in bits [2:0] of command word 0
    // Codes 6 and 7 are not defined and get skipped by the sequencer
    typedef enum logic [2:0] {
        OP_IDLE      = 3'd0,
        OP_CONV1     = 3'd1,
        OP_CONV3     = 3'd2,
        OP_CONV3_PAD = 3'd3,
        OP_MAXPOOL3  = 3'd4,
        OP_AVEPOOL13 = 3'd5
    } op_type_e;

    // Words per packed command
    localparam int CMD_WORDS = 6;

    // Engine parallelism, 16 channels of 4 bytes per group
    localparam int GROUP_CH    = 16;
    localparam int GROUP_BYTES = 64;
    localparam int GROUP_IDX_W = 12;

    // Bit positions inside the command words
    localparam int W0_PAD_BIT    = 4;
    localparam int W0_STRIDE_LSB = 8;
    localparam int W0_OPNUM_LSB  = 12;
    localparam int W1_OCH_LSB    = 16;
    localparam int W2_OKER_LSB   = 8;

    // Decoded layer descriptor, 192 bits of command minus spare bits
    typedef struct packed {
        op_type_e    op_type;
        logic        padding;
        logic [3:0]  stride;
        logic [19:0] op_num;
        logic [15:0] i_channel_size;
        logic [15:0] o_channel_size;
        logic [7:0]  i_kernel_size;
        logic [7:0]  o_kernel_size;
        logic [31:0] weight_start_addr;
        logic [31:0] data_start_addr;
        logic [31:0] writeback_addr;
    } layer_cmd_t;

    // One writeback per finished channel group
    typedef struct packed {
        op_type_e               op_type;
        logic [GROUP_IDX_W-1:0] group_idx;
        logic [31:0]            addr;
    } wb_beat_t;

    // Conv and pooling codes that start the engine
    function automatic logic op_valid(input op_type_e op);
        return (op != OP_IDLE) && (op <= OP_AVEPOOL13);
    endfunction

endpackage

//--- verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo import cnn_pkg::*; #(
    parameter int  DEPTH = 16,
    parameter type T     = logic [31:0],
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    localparam int CW    = $clog2(DEPTH + 1)
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_wr_en,
    input  T              i_wr_data,
    input  logic          i_rd_en,
    output T              o_rd_data,
    output logic          o_empty,
    output logic          o_full,
    output logic [CW-1:0] o_count
);

    // Storage, no reset needed on the data array
    T mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_wr;
    logic          do_rd;

    // Overflow and underflow requests are dropped
    assign do_wr = i_wr_en && !o_full;
    assign do_rd = i_rd_en && !o_empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Pointers wrap at DEPTH, so depth need not be a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Fill level moves only on unbalanced access
            case ({do_wr, do_rd})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;
            endcase
        end
    end

    // Head word visible without a read, first-word-fall-through
    assign o_rd_data = mem[rd_ptr];
    assign o_empty   = (o_count == '0);
    assign o_full    = (o_count == CW'(DEPTH));

endmodule

//--- verilog/cmd_dma.sv
`timescale 1ns/1ps

module cmd_dma import cnn_pkg::*; #(
    parameter int  CMD_DEPTH = 256,
    localparam int AW        = $clog2(CMD_DEPTH)
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          i_op_en,
    input  logic [6:0]    i_cmd_size,
    input  logic          i_cmd_we,
    input  logic [AW-1:0] i_cmd_addr,
    input  logic [31:0]   i_cmd_wdata,
    input  logic          i_fifo_full,
    output logic          o_fifo_wr_en,
    output logic [31:0]   o_fifo_wdata,
    output logic          o_fetch_done
);

    // Command store, loaded by the host before op_en
    logic [31:0] mem [CMD_DEPTH];

    logic [AW-1:0] rd_ptr;
    // Up to 127 commands of 6 words fits in 10 bits
    logic [9:0]    word_cnt;
    logic [9:0]    word_target;

    always_ff @(posedge clk) begin
        if (i_cmd_we) begin
            mem[i_cmd_addr] <= i_cmd_wdata;
        end
    end

    // Push while words remain and the FIFO has room
    assign o_fifo_wr_en = (word_cnt != word_target) && !i_fifo_full;
    assign o_fifo_wdata = mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr       <= '0;
            word_cnt     <= '0;
            word_target  <= '0;
            o_fetch_done <= 1'b0;
        end else if (i_op_en) begin
            // New run restarts from word 0
            rd_ptr       <= '0;
            word_cnt     <= '0;
            word_target  <= 10'(i_cmd_size) * 10'(CMD_WORDS);
            // Empty command list is done at once
            o_fetch_done <= (i_cmd_size == '0);
        end else if (o_fifo_wr_en) begin
            rd_ptr   <= rd_ptr + 1'b1;
            word_cnt <= word_cnt + 1'b1;
            // Last word of the list leaves the memory
            if (word_cnt == word_target - 1'b1) begin
                o_fetch_done <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer import cnn_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_op_en,
    input  logic        i_fetch_done,
    input  logic [31:0] i_cmd_word,
    input  logic        i_cmd_empty,
    output logic        o_cmd_rd_en,
    output layer_cmd_t  o_layer,
    output logic        o_engine_start,
    output logic        o_engine_reset,
    input  logic        i_group_done,
    output logic        o_op_run,
    output logic        o_irq
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_COLLECT,
        S_ISSUE,
        S_WAIT_OP,
        S_FINISH
    } seq_state_e;

    seq_state_e state;

    // Position of the next word inside the command
    logic [2:0]             word_cnt;
    logic                   last_word;
    // Groups finished in the current layer and groups required
    logic [GROUP_IDX_W-1:0] grp_cnt;
    logic [GROUP_IDX_W-1:0] grp_target;
    logic                   layer_last_grp;
    // Nothing left in the FIFO and nothing more to come
    logic                   no_more_cmds;
    seq_state_e             after_layer;

    // Pop one word per non-empty collect cycle
    assign o_cmd_rd_en = (state == S_COLLECT) && !i_cmd_empty;
    assign last_word   = (word_cnt == 3'(CMD_WORDS - 1));

    assign grp_target     = GROUP_IDX_W'(o_layer.o_channel_size / GROUP_CH);
    assign layer_last_grp = i_group_done && (grp_cnt + 1'b1 == grp_target);
    assign no_more_cmds   = i_cmd_empty && i_fetch_done;
    assign after_layer    = no_more_cmds ? S_FINISH : S_COLLECT;

    // Run and irq are decoded from state, so they never overlap
    assign o_op_run = (state == S_COLLECT) || (state == S_ISSUE) || (state == S_WAIT_OP);
    assign o_irq    = (state == S_FINISH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= S_IDLE;
            word_cnt       <= '0;
            grp_cnt        <= '0;
            o_engine_start <= 1'b0;
            o_engine_reset <= 1'b1;
        end else begin
            case (state)
                S_IDLE, S_FINISH: begin
                    // op_en also clears irq by leaving finish
                    if (i_op_en) begin
                        state    <= S_COLLECT;
                        word_cnt <= '0;
                    end
                end
                S_COLLECT: begin
                    if (o_cmd_rd_en) begin
                        word_cnt <= last_word ? '0 : word_cnt + 1'b1;
                        if (last_word) begin
                            grp_cnt <= '0;
                            // op_type and channel count were latched from words 0 and 1
                            if (op_valid(o_layer.op_type) && (grp_target != '0)) begin
                                state          <= S_ISSUE;
                                o_engine_start <= 1'b1;
                                o_engine_reset <= 1'b0;
                            end else begin
                                // Skipped layer, go straight on
                                state <= after_layer;
                            end
                        end
                    end else if ((word_cnt == '0) && no_more_cmds) begin
                        // Covers an empty command list
                        state <= S_FINISH;
                    end
                end
                S_ISSUE, S_WAIT_OP: begin
                    // Short kernels can finish a group during issue
                    if (state == S_ISSUE) begin
                        state <= S_WAIT_OP;
                    end
                    if (i_group_done) begin
                        grp_cnt <= grp_cnt + 1'b1;
                    end
                    if (layer_last_grp) begin
                        o_engine_start <= 1'b0;
                        o_engine_reset <= 1'b1;
                        state          <= after_layer;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Split each word into descriptor fields
    always_ff @(posedge clk) begin
        if (o_cmd_rd_en) begin
            case (word_cnt)
                3'd0: begin
                    o_layer.op_type <= op_type_e'(i_cmd_word[2:0]);
                    o_layer.padding <= i_cmd_word[W0_PAD_BIT];
                    o_layer.stride  <= i_cmd_word[W0_STRIDE_LSB +: 4];
                    o_layer.op_num  <= i_cmd_word[W0_OPNUM_LSB +: 20];
                end
                3'd1: begin
                    o_layer.i_channel_size <= i_cmd_word[15:0];
                    o_layer.o_channel_size <= i_cmd_word[W1_OCH_LSB +: 16];
                end
                3'd2: begin
                    o_layer.i_kernel_size <= i_cmd_word[7:0];
                    o_layer.o_kernel_size <= i_cmd_word[W2_OKER_LSB +: 8];
                end
                3'd3: o_layer.weight_start_addr <= i_cmd_word;
                3'd4: o_layer.data_start_addr   <= i_cmd_word;
                3'd5: o_layer.writeback_addr    <= i_cmd_word;
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/group_engine.sv
`timescale 1ns/1ps

module group_engine import cnn_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_start,
    input  logic       i_reset,
    input  layer_cmd_t i_layer,
    input  logic       i_wb_full,
    output logic       o_wb_wr_en,
    output wb_beat_t   o_wb_beat,
    output logic       o_group_done
);

    // Cost of one group is the input kernel area
    logic [15:0]            ksq;
    logic [15:0]            last_cyc;
    logic [15:0]            cyc_cnt;
    logic                   at_last;
    logic [GROUP_IDX_W-1:0] grp_idx;

    assign ksq      = 16'(i_layer.i_kernel_size) * 16'(i_layer.i_kernel_size);
    // Zero kernel treated as a single cycle
    assign last_cyc = (ksq == '0) ? '0 : ksq - 1'b1;
    assign at_last  = (cyc_cnt == last_cyc);

    // Beat leaves on the last counting cycle, or later once the FIFO drains
    assign o_wb_wr_en   = i_start && at_last && !i_wb_full;
    assign o_group_done = o_wb_wr_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc_cnt <= '0;
            grp_idx <= '0;
        end else if (i_reset) begin
            // Between layers
            cyc_cnt <= '0;
            grp_idx <= '0;
        end else if (i_start) begin
            if (at_last) begin
                // Counter parks here while the FIFO is full
                if (!i_wb_full) begin
                    cyc_cnt <= '0;
                    grp_idx <= grp_idx + 1'b1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    // Beat fields stay stable while the push waits
    always_comb begin
        o_wb_beat.op_type   = i_layer.op_type;
        o_wb_beat.group_idx = grp_idx;
        // Target address steps one group of 64 bytes at a time
        o_wb_beat.addr      = i_layer.writeback_addr
                            + 32'(grp_idx) * 32'(GROUP_BYTES);
    end

endmodule

//--- verilog/cnn_ctrl_top.sv
`timescale 1ns/1ps

module cnn_ctrl_top import cnn_pkg::*; #(
    parameter int  CMD_DEPTH      = 256,
    parameter int  CMD_FIFO_DEPTH = 16,
    parameter int  WB_FIFO_DEPTH  = 8,
    localparam int CMD_AW         = $clog2(CMD_DEPTH)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_op_en,
    input  logic [6:0]        i_cmd_size,
    input  logic              i_cmd_we,
    input  logic [CMD_AW-1:0] i_cmd_addr,
    input  logic [31:0]       i_cmd_wdata,
    input  logic              i_wb_rd_en,
    output logic              o_wb_empty,
    output wb_beat_t          o_wb_beat,
    output logic              o_op_run,
    output logic              o_irq
);

    // Fetch side
    logic        cmd_wr_en;
    logic [31:0] cmd_wdata;
    logic        cmd_full;
    logic        fetch_done;
    // Sequencer side of the command FIFO
    logic        cmd_rd_en;
    logic [31:0] cmd_word;
    logic        cmd_empty;
    // Sequencer to engine
    layer_cmd_t  layer;
    logic        engine_start;
    logic        engine_reset;
    logic        group_done;
    // Engine to writeback FIFO
    logic        wb_wr_en;
    wb_beat_t    wb_beat;
    logic        wb_full;

    cmd_dma #(
        .CMD_DEPTH (CMD_DEPTH)
    ) cmd_dma_inst (
        .clk          (clk),
        .rst          (rst),
        .i_op_en      (i_op_en),
        .i_cmd_size   (i_cmd_size),
        .i_cmd_we     (i_cmd_we),
        .i_cmd_addr   (i_cmd_addr),
        .i_cmd_wdata  (i_cmd_wdata),
        .i_fifo_full  (cmd_full),
        .o_fifo_wr_en (cmd_wr_en),
        .o_fifo_wdata (cmd_wdata),
        .o_fetch_done (fetch_done)
    );

    sync_fifo #(
        .DEPTH (CMD_FIFO_DEPTH),
        .T     (logic [31:0])
    ) cmd_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .i_wr_en   (cmd_wr_en),
        .i_wr_data (cmd_wdata),
        .i_rd_en   (cmd_rd_en),
        .o_rd_data (cmd_word),
        .o_empty   (cmd_empty),
        .o_full    (cmd_full),
        .o_count   ()
    );

    layer_sequencer layer_sequencer_inst (
        .clk            (clk),
        .rst            (rst),
        .i_op_en        (i_op_en),
        .i_fetch_done   (fetch_done),
        .i_cmd_word     (cmd_word),
        .i_cmd_empty    (cmd_empty),
        .o_cmd_rd_en    (cmd_rd_en),
        .o_layer        (layer),
        .o_engine_start (engine_start),
        .o_engine_reset (engine_reset),
        .i_group_done   (group_done),
        .o_op_run       (o_op_run),
        .o_irq          (o_irq)
    );

    group_engine group_engine_inst (
        .clk          (clk),
        .rst          (rst),
        .i_start      (engine_start),
        .i_reset      (engine_reset),
        .i_layer      (layer),
        .i_wb_full    (wb_full),
        .o_wb_wr_en   (wb_wr_en),
        .o_wb_beat    (wb_beat),
        .o_group_done (group_done)
    );

    sync_fifo #(
        .DEPTH (WB_FIFO_DEPTH),
        .T     (wb_beat_t)
    ) wb_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .i_wr_en   (wb_wr_en),
        .i_wr_data (wb_beat),
        .i_rd_en   (i_wb_rd_en),
        .o_rd_data (o_wb_beat),
        .o_empty   (o_wb_empty),
        .o_full    (wb_full),
        .o_count   ()
    );

endmodule

//--- sim/cnn_ctrl_assert.sv
`timescale 1ns/1ps

module cnn_ctrl_assert import cnn_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       i_irq,
    input logic       i_op_run,
    input logic       i_engine_start,
    input layer_cmd_t i_layer,
    input logic       i_cmd_rd_en,
    input logic       i_cmd_empty
);

    // Codes 0, 6 and 7 never start the engine
    logic op_bad;
    assign op_bad = i_layer.op_type inside {3'd0, 3'd6, 3'd7};

    // Finish and running states are exclusive
    irq_run_excl: assert property (@(posedge clk) disable iff (rst)
        !(i_irq && i_op_run))
        else $error("irq and op_run high together");

    start_op_valid: assert property (@(posedge clk) disable iff (rst)
        !(i_engine_start && op_bad))
        else $error("engine start with an invalid op_type");

    // No pop from an empty command FIFO
    rd_not_empty: assert property (@(posedge clk) disable iff (rst)
        !(i_cmd_rd_en && i_cmd_empty))
        else $error("command read strobe while FIFO empty");

endmodule

bind layer_sequencer cnn_ctrl_assert seq_assert_inst (
    .clk            (clk),
    .rst            (rst),
    .i_irq          (o_irq),
    .i_op_run       (o_op_run),
    .i_engine_start (o_engine_start),
    .i_layer        (o_layer),
    .i_cmd_rd_en    (o_cmd_rd_en),
    .i_cmd_empty    (i_cmd_empty)
);

//--- sim/cnn_ctrl_tb.sv
`timescale 1ns/1ps

module cnn_ctrl_tb import cnn_pkg::*; ();

    localparam int CMD_DEPTH      = 256;
    localparam int CMD_FIFO_DEPTH = 16;
    localparam int WB_FIFO_DEPTH  = 8;
    localparam int CMD_AW         = $clog2(CMD_DEPTH);
    localparam int CLK_HALF       = 2;
    localparam int NUM_RUNS       = 4;

    typedef wb_beat_t   beat_q_t[$];
    typedef layer_cmd_t cmd_q_t[$];

    logic              clk = 1'b0;
    logic              rst;
    logic              i_op_en;
    logic [6:0]        i_cmd_size;
    logic              i_cmd_we;
    logic [CMD_AW-1:0] i_cmd_addr;
    logic [31:0]       i_cmd_wdata;
    logic              i_wb_rd_en = 1'b0;
    logic              o_wb_empty;
    wb_beat_t          o_wb_beat;
    logic              o_op_run;
    logic              o_irq;

    integer     seed = 32'hd88f9a42;
    // All command lists back to back, split by run_len
    layer_cmd_t all_cmds[$];
    int         run_len[NUM_RUNS];
    int         stall_pct[NUM_RUNS];
    // Beats still owed by the DUT, oldest first
    beat_q_t    exp_q;
    int         stall_now;
    int         budget_cycles;
    bit         budget_ready = 1'b0;

    cnn_ctrl_top #(
        .CMD_DEPTH      (CMD_DEPTH),
        .CMD_FIFO_DEPTH (CMD_FIFO_DEPTH),
        .WB_FIFO_DEPTH  (WB_FIFO_DEPTH)
    ) cnn_ctrl_top_inst (
        .clk         (clk),
        .rst         (rst),
        .i_op_en     (i_op_en),
        .i_cmd_size  (i_cmd_size),
        .i_cmd_we    (i_cmd_we),
        .i_cmd_addr  (i_cmd_addr),
        .i_cmd_wdata (i_cmd_wdata),
        .i_wb_rd_en  (i_wb_rd_en),
        .o_wb_empty  (o_wb_empty),
        .o_wb_beat   (o_wb_beat),
        .o_op_run    (o_op_run),
        .o_irq       (o_irq)
    );

    always #CLK_HALF clk = ~clk;

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // Fields the sequencer only carries get random values
    function automatic layer_cmd_t make_cmd(input int op, input int och, input int ik,
                                            input logic [31:0] wb);
        layer_cmd_t c;
        c.op_type           = op_type_e'(3'(op));
        c.padding           = 1'(rand_range(0, 1));
        c.stride            = 4'(rand_range(1, 2));
        c.op_num            = 20'(rand_range(0, 1000));
        c.i_channel_size    = 16'(rand_range(1, 256));
        c.o_channel_size    = 16'(och);
        c.i_kernel_size     = 8'(ik);
        c.o_kernel_size     = 8'(ik);
        c.weight_start_addr = rand_word();
        c.data_start_addr   = rand_word();
        c.writeback_addr    = wb;
        return c;
    endfunction

    // Packed word layout of one command
    function automatic logic [31:0] encode_word(input layer_cmd_t c, input int idx);
        logic [31:0] w;
        case (idx)
            0: w = {c.op_num, c.stride, 3'b000, c.padding, 1'b0, c.op_type};
            1: w = {c.o_channel_size, c.i_channel_size};
            2: w = {16'h0000, c.o_kernel_size, c.i_kernel_size};
            3: w = c.weight_start_addr;
            4: w = c.data_start_addr;
            default: w = c.writeback_addr;
        endcase
        return w;
    endfunction

    // Reference model, one beat per 16-channel group of each valid layer
    function automatic beat_q_t model_beats(input cmd_q_t cmds);
        beat_q_t  q;
        wb_beat_t b;
        int       n;
        foreach (cmds[i]) begin
            if (cmds[i].op_type inside {OP_CONV1, OP_CONV3, OP_CONV3_PAD,
                                        OP_MAXPOOL3, OP_AVEPOOL13}) begin
                n = int'(cmds[i].o_channel_size) / 16;
                for (int g = 0; g < n; g++) begin
                    b.op_type   = cmds[i].op_type;
                    b.group_idx = 12'(g);
                    b.addr      = cmds[i].writeback_addr + 32'(g * 64);
                    q.push_back(b);
                end
            end
        end
        return q;
    endfunction

    // Kernel area per group plus slack for stalls, fetch and collect
    function automatic int test_budget();
        int cycles;
        int ksq;
        cycles = 10;
        foreach (all_cmds[i]) begin
            ksq = int'(all_cmds[i].i_kernel_size) * int'(all_cmds[i].i_kernel_size);
            if (ksq == 0) begin
                ksq = 1;
            end
            cycles += 18 + (int'(all_cmds[i].o_channel_size) / 16) * (ksq + 16);
        end
        return cycles + NUM_RUNS * 200;
    endfunction

    task automatic build_runs();
        // Single 1x1 conv, four groups
        all_cmds.push_back(make_cmd(1, 64, 1, 32'h1000_0000));
        run_len[0]   = 1;
        stall_pct[0] = 0;
        // Mixed ops, an invalid code and a zero-channel layer
        all_cmds.push_back(make_cmd(2, 32, 3, 32'h2000_0000));
        all_cmds.push_back(make_cmd(4, 48, 3, 32'h2100_0000));
        all_cmds.push_back(make_cmd(6, 32, 3, 32'h2200_0000));
        all_cmds.push_back(make_cmd(5, 16, 13, 32'h2300_0000));
        all_cmds.push_back(make_cmd(1, 0, 1, 32'h2400_0000));
        all_cmds.push_back(make_cmd(3, 32, 3, 32'h2500_0000));
        run_len[1]   = 6;
        stall_pct[1] = 0;
        // Fast groups against a mostly stalled reader
        for (int i = 0; i < 4; i++) begin
            all_cmds.push_back(make_cmd(rand_range(1, 5), 128, 1,
                                        rand_word() & 32'hffff_f000));
        end
        run_len[2]   = 4;
        stall_pct[2] = 75;
        // Long list, more words than the command FIFO holds
        for (int i = 0; i < 20; i++) begin
            all_cmds.push_back(make_cmd(rand_range(0, 7), 16 * rand_range(1, 4),
                                        rand_range(1, 3), rand_word() & 32'hffff_f000));
        end
        run_len[3]   = 20;
        stall_pct[3] = 30;
    endtask

    task automatic load_commands(input cmd_q_t cmds);
        int addr;
        addr = 0;
        foreach (cmds[i]) begin
            for (int w = 0; w < 6; w++) begin
                @(negedge clk);
                i_cmd_we    = 1'b1;
                i_cmd_addr  = CMD_AW'(addr);
                i_cmd_wdata = encode_word(cmds[i], w);
                addr++;
            end
        end
        @(negedge clk);
        i_cmd_we = 1'b0;
    endtask

    task automatic run_list(input cmd_q_t cmds, input int stall, input bit first);
        beat_q_t exp;
        load_commands(cmds);
        exp = model_beats(cmds);
        foreach (exp[i]) begin
            exp_q.push_back(exp[i]);
        end
        stall_now = stall;
        if (first) begin
            assert (!o_irq) else fail_stop("irq high before the first op_en");
        end else begin
            assert (o_irq) else fail_stop("irq not held high between runs");
        end
        i_cmd_size = 7'(cmds.size());
        i_op_en    = 1'b1;
        @(negedge clk);
        i_op_en = 1'b0;
        assert (!o_irq) else fail_stop("irq did not drop after op_en");
        while (!o_irq) begin
            assert (o_op_run) else fail_stop("op_run low while layers still run");
            @(negedge clk);
        end
        // Beats not yet popped must all sit in the writeback FIFO
        assert (exp_q.size() <= WB_FIFO_DEPTH && (exp_q.size() == 0 || !o_wb_empty))
            else fail_stop("irq rose before the last writeback beat");
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        assert (o_wb_empty) else fail_stop("extra writeback beat after the expected list");
        assert (o_irq) else fail_stop("irq dropped without op_en");
        stall_now = 0;
    endtask

    // Pops on every non-stalled cycle and checks the head beat
    always @(negedge clk) begin : beat_compare
        wb_beat_t want;
        bit       stall;
        i_wb_rd_en = 1'b0;
        stall = (stall_now > 0) && (rand_range(0, 99) < stall_now);
        if (!rst && !o_wb_empty && !stall) begin
            assert (exp_q.size() != 0) else fail_stop("writeback beat with none expected");
            want = exp_q.pop_front();
            assert (o_wb_beat == want) else
                fail_stop($sformatf("[FAIL] o_wb_beat expected %h actual %h", want, o_wb_beat));
            i_wb_rd_en = 1'b1;
        end
    end

    initial begin : watchdog
        wait (budget_ready);
        repeat (budget_cycles) @(posedge clk);
        fail_stop($sformatf("Timeout after %0d cycles, irq or beats never arrived",
                            budget_cycles));
    end

    initial begin : main_flow
        cmd_q_t run_cmds;
        int     first_idx;
        rst         = 1'b1;
        i_op_en     = 1'b0;
        i_cmd_size  = '0;
        i_cmd_we    = 1'b0;
        i_cmd_addr  = '0;
        i_cmd_wdata = '0;
        stall_now   = 0;
        build_runs();
        budget_cycles = test_budget();
        budget_ready  = 1'b1;
        repeat (3) @(negedge clk);
        rst       = 1'b0;
        first_idx = 0;
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_cmds.delete();
            for (int i = 0; i < run_len[r]; i++) begin
                run_cmds.push_back(all_cmds[first_idx + i]);
            end
            first_idx += run_len[r];
            run_list(run_cmds, stall_pct[r], r == 0);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- files.f
verilog/cnn_pkg.sv
verilog/sync_fifo.sv
verilog/cmd_dma.sv
verilog/layer_sequencer.sv
verilog/group_engine.sv
verilog/cnn_ctrl_top.sv
sim/cnn_ctrl_assert.sv
sim/cnn_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module cnn_ctrl_tb \
    -o cnn_ctrl_sim

# Exit status comes from the search for the pass line
./obj_dir/cnn_ctrl_sim | tee /dev/stderr | grep -q "Regression passed"
echo "Simulation passed"
